/* bench/shared_ram_trace.txt */
// req cmd0 cmd1 cmd2 cmd3 grant rsp_valid rsp_data, all hex, one line per cycle
// cmd bit 12 write, bits 11:8 addr, bits 7:0 data or bit 7 clear on reads
// idle just after reset
0 0000 0000 0000 0000 0 0 00
0 0000 0000 0000 0000 0 0 00
// all clients write, rotation 0 1 2 3 0
F 1011 1122 1233 1344 1 0 00
F 1455 1122 1233 1344 2 0 00
F 1455 1566 1233 1344 4 0 00
F 1455 1566 1677 1344 8 0 00
F 1455 1566 1677 1788 1 0 00
E 0000 1566 1677 1788 2 0 00
C 0000 0000 1677 1788 4 0 00
8 0000 0000 0000 1788 8 0 00
0 0000 0000 0000 0000 0 0 00
// sparse reads, clients 1 and 3 then client 0 joins
A 0000 0100 0000 0300 2 0 00
9 0000 0000 0000 0300 8 0 00
1 0000 0000 0000 0000 1 2 22
0 0000 0000 0000 0000 0 8 44
0 0000 0000 0000 0000 0 1 11
0 0000 0000 0000 0000 0 0 00
// write then read of address 9 by client 2
4 0000 0000 19A5 0000 4 0 00
4 0000 0000 0900 0000 4 0 00
0 0000 0000 0000 0000 0 0 00
0 0000 0000 0000 0000 0 4 A5
// read-clear of address 6 then plain read
8 0000 0000 0000 0680 8 0 00
2 0000 0600 0000 0000 2 0 00
0 0000 0000 0000 0000 0 8 77
0 0000 0000 0000 0000 0 2 00
0 0000 0000 0000 0000 0 0 00

/* sources.f */
+incdir+common
common/arb_pkg.sv
common/mem_pkg.sv
common/mem_port_if.sv
arbiter/arbiter_round_robin.sv
arbiter/access_arbiter.sv
rtl/shared_ram.sv
rtl/shared_ram_top.sv
bench/shared_ram_checker.sv
bench/shared_ram_tb.sv

/* Bender.yml */
package:
  name: shared_ram

sources:
  - include_dirs:
      - common
    files:
      - common/arb_pkg.sv
      - common/mem_pkg.sv
      - common/mem_port_if.sv
      - arbiter/arbiter_round_robin.sv
      - arbiter/access_arbiter.sv
      - rtl/shared_ram.sv
      - rtl/shared_ram_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/shared_ram_checker.sv
      - bench/shared_ram_tb.sv

/* bench/shared_ram_tb.sv */
// Shared scratch memory testbench

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module shared_ram_tb
    import arb_pkg::*, mem_pkg::*;
();

    localparam int N             = `ARB_NUM_CLIENTS;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 5;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 20;
    localparam int MAX_LINES     = 64;

    // DUT ports
    logic           clk;
    logic           rst;
    client_mask_t   req;
    mem_cmd_t [N-1:0] cmd;
    client_mask_t   grant;
    client_mask_t   rsp_valid;
    mem_word_t      rsp_data;

    // Trace contents, one entry per cycle
    client_mask_t     trace_req       [MAX_LINES];
    mem_cmd_t [N-1:0] trace_cmd       [MAX_LINES];
    client_mask_t     trace_grant     [MAX_LINES];
    client_mask_t     trace_rsp_valid [MAX_LINES];
    mem_word_t        trace_rsp_data  [MAX_LINES];
    int               trace_line_no   [MAX_LINES];
    int               line_count;
    bit               trace_loaded;

    shared_ram_top shared_ram_top_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .cmd       (cmd),
        .grant     (grant),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Non-value failure ends the run
    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Trace columns are req, four command words, grant, response mask and response data
    task automatic load_trace();
        int               fd;
        int               code;
        int               file_line;
        logic [8*160-1:0] text;
        logic [15:0]      f [8];
        fd = $fopen("bench/shared_ram_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/shared_ram_trace.txt");
        end
        file_line = 0;
        while ($fgets(text, fd) != 0) begin
            file_line++;
            code = $sscanf(text, "%h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            // Comment and blank lines match nothing
            if (code == 8) begin
                if (line_count == MAX_LINES) begin
                    abort_run("trace file has more lines than the bench can hold");
                end
                trace_req[line_count] = f[0][N-1:0];
                for (int k = 0; k < N; k++) begin
                    trace_cmd[line_count][k] = f[k + 1][$bits(mem_cmd_t)-1:0];
                end
                trace_grant[line_count]     = f[5][N-1:0];
                trace_rsp_valid[line_count] = f[6][N-1:0];
                trace_rsp_data[line_count]  = f[7][`ARB_DATA_W-1:0];
                trace_line_no[line_count]   = file_line;
                line_count++;
            end else if (code > 0) begin
                abort_run($sformatf("trace line %0d is incomplete", file_line));
            end
        end
        $fclose(fd);
        if (line_count == 0) begin
            abort_run("trace file holds no stimulus lines");
        end
    endtask

    // ------------------------------------------------------------------------
    // Clock and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Budget is reset plus trace plus slack
    initial begin
        wait (trace_loaded);
        #((line_count + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abort_run("watchdog timeout, trace did not finish in time");
    end

    // ------------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        req        = '0;
        cmd        = '0;
        line_count = 0;
        load_trace();
        trace_loaded = 1'b1;

        // Outputs stay quiet through reset
        // Rst drops after the 16th edge
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (c == RESET_CYCLES - 1) begin
                rst = 1'b0;
            end
            @(negedge clk);
            compare_value("reset grant", '0, grant);
            compare_value("reset rsp_valid", '0, rsp_valid);
        end

        // One trace line per cycle
        // Outputs sampled mid-cycle
        for (int i = 0; i < line_count; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            req = trace_req[i];
            cmd = trace_cmd[i];
            @(negedge clk);
            compare_value($sformatf("trace line %0d grant", trace_line_no[i]),
                          trace_grant[i], grant);
            compare_value($sformatf("trace line %0d rsp_valid", trace_line_no[i]),
                          trace_rsp_valid[i], rsp_valid);
            // Data only meaningful with a strobe
            if (trace_rsp_valid[i] != '0) begin
                compare_value($sformatf("trace line %0d rsp_data", trace_line_no[i]),
                              trace_rsp_data[i], rsp_data);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : shared_ram_tb

`default_nettype wire

/* bench/shared_ram_checker.sv */
// Grant and response protocol assertions

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module shared_ram_checker
    import arb_pkg::*, mem_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  client_mask_t                    req,
    input  mem_cmd_t [`ARB_NUM_CLIENTS-1:0] cmd,
    input  client_mask_t                    grant,
    input  client_mask_t                    rsp_valid
);

    // ------------------------------------------------------------------------
    // Grant rules
    // ------------------------------------------------------------------------

    // At most one winner per cycle
    grant_onehot_a: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant has more than one bit set: %b", grant);

    // Only requesting clients win
    grant_subset_a: assert property (@(posedge clk) disable iff (rst) (grant & ~req) == '0)
        else $error("grant %b outside request %b", grant, req);

    // ------------------------------------------------------------------------
    // Response rules
    // ------------------------------------------------------------------------
    rsp_onehot_a: assert property (@(posedge clk) disable iff (rst) $onehot0(rsp_valid))
        else $error("rsp_valid has more than one bit set: %b", rsp_valid);

    // Fixed two-cycle read latency, per client
    for (genvar i = 0; i < `ARB_NUM_CLIENTS; i++) begin : g_read_return
        read_return_a: assert property (@(posedge clk) disable iff (rst)
            (grant[i] && (cmd[i].rd.op == MEM_READ)) |-> ##2 rsp_valid[i])
            else $error("client %0d read not answered two cycles after grant", i);
    end

endmodule : shared_ram_checker

bind shared_ram_top shared_ram_checker shared_ram_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .cmd       (cmd),
    .grant     (grant),
    .rsp_valid (rsp_valid)
);

`default_nettype wire

/* rtl/shared_ram_top.sv */
// Shared scratch memory top

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module shared_ram_top
    import arb_pkg::*, mem_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  client_mask_t                    req,
    input  mem_cmd_t [`ARB_NUM_CLIENTS-1:0] cmd,
    output client_mask_t                    grant,
    output client_mask_t                    rsp_valid,
    output mem_word_t                       rsp_data
);

    // Issued command, arbiter to memory
    mem_port_if mem_port_inst ();

    // Grant and issue
    access_arbiter access_arbiter_inst (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .cmd   (cmd),
        .grant (grant),
        .port  (mem_port_inst.arb)
    );

    // Array and read responses
    shared_ram shared_ram_inst (
        .clk       (clk),
        .rst       (rst),
        .port      (mem_port_inst.mem),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

endmodule : shared_ram_top

`default_nettype wire

/* rtl/shared_ram.sv */
// Shared scratch memory

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module shared_ram
    import arb_pkg::*, mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    mem_port_if.mem      port,
    output client_mask_t rsp_valid,
    output mem_word_t    rsp_data
);

    localparam int DEPTH = 2 ** `ARB_ADDR_W;

    // Storage, no reset
    mem_word_t mem_array [DEPTH];

    // Command decode
    logic                   is_write;
    logic                   is_read;
    logic [`ARB_ADDR_W-1:0] addr;

    // Opcode and address sit in the same bits of both views
    assign is_write = port.valid && (port.cmd.wr.op == MEM_WRITE);
    assign is_read  = port.valid && (port.cmd.rd.op == MEM_READ);
    assign addr     = port.cmd.wr.addr;

    // ------------------------------------------------------------------------
    // Array access
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (is_write) begin
            mem_array[addr] <= port.cmd.wr.data;
        end else if (is_read) begin
            // Old word out, zero in when clearing
            rsp_data <= mem_array[addr];
            if (port.cmd.rd.clear) begin
                mem_array[addr] <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Response strobe
    // ------------------------------------------------------------------------

    // Client index to one-hot, reads only
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= '0;
        end else if (is_read) begin
            rsp_valid <= client_mask_t'(1) << port.client;
        end else begin
            rsp_valid <= '0;
        end
    end

endmodule : shared_ram

`default_nettype wire

/* arbiter/access_arbiter.sv */
// Client access arbiter

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module access_arbiter
    import arb_pkg::*, mem_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  client_mask_t                        req,
    input  mem_cmd_t [`ARB_NUM_CLIENTS-1:0]     cmd,
    output client_mask_t                        grant,
    mem_port_if.arb                             port
);

    // Arbiter outputs
    logic         grant_valid;
    client_mask_t grant_onehot;
    client_id_t   grant_id;

    // Command of the winning client
    mem_cmd_t     grant_cmd;

    // ------------------------------------------------------------------------
    // Arbitration
    // ------------------------------------------------------------------------
    arbiter_round_robin arbiter_round_robin_inst (
        .clk         (clk),
        .rst         (rst),
        .request     (req),
        .grant_valid (grant_valid),
        .grant       (grant_onehot),
        .grant_id    (grant_id)
    );

    // Grant pulse straight back to the clients, same cycle as req
    assign grant = grant_onehot;

    // Index select of the held command
    assign grant_cmd = cmd[grant_id];

    // ------------------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------------------

    // Valid one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            port.valid <= 1'b0;
        end else begin
            port.valid <= grant_valid;
        end
    end

    // Payload, qualified by valid
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            port.cmd    <= grant_cmd;
            port.client <= grant_id;
        end
    end

endmodule : access_arbiter

`default_nettype wire

/* arbiter/arbiter_round_robin.sv */
// Rotating-priority arbiter

`default_nettype none
`timescale 1ns/10ps

`include "arb_settings.svh"

module arbiter_round_robin
    import arb_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  client_mask_t request,
    output logic         grant_valid,
    output client_mask_t grant,
    output client_id_t   grant_id
);

    localparam int N = `ARB_NUM_CLIENTS;

    // ------------------------------------------------------------------------
    // Priority state
    // ------------------------------------------------------------------------

    // Index of the client granted last
    client_id_t   last_grant;

    // Scan starts one past the last grant
    client_id_t   shift_amount;

    client_mask_t rot_req;
    client_mask_t rot_sel;
    client_mask_t nxt_grant;
    client_id_t   nxt_id;

    // Wrap to zero after the top client
    assign shift_amount = (last_grant == client_id_t'(N-1)) ? '0 : client_id_t'(last_grant + 1);

    // ------------------------------------------------------------------------
    // Rotate, isolate, rotate back
    // ------------------------------------------------------------------------
    always_comb begin
        // Start client moves down to bit 0
        if (shift_amount == '0) begin
            rot_req = request;
        end else begin
            rot_req = (request >> shift_amount) | (request << (N - int'(shift_amount)));
        end

        // Lowest set bit wins, zero stays zero
        rot_sel = rot_req & ((~rot_req) + client_mask_t'(1));

        // Back to client positions
        if (shift_amount == '0) begin
            nxt_grant = rot_sel;
        end else begin
            nxt_grant = (rot_sel << shift_amount) | (rot_sel >> (N - int'(shift_amount)));
        end
    end

    // One-hot to index
    always_comb begin
        // Holds last grant when nothing requests
        nxt_id = last_grant;
        for (int i = 0; i < N; i++) begin
            if (nxt_grant[i]) begin
                nxt_id = client_id_t'(i);
            end
        end
    end

    assign grant       = nxt_grant;
    assign grant_valid = |nxt_grant;
    assign grant_id    = nxt_id;

    // Top client as last grant puts client 0 first after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= client_id_t'(N-1);
        end else if (grant_valid) begin
            last_grant <= nxt_id;
        end
    end

endmodule : arbiter_round_robin

`default_nettype wire

/* common/mem_port_if.sv */
// Memory command port

`default_nettype none
`timescale 1ns/10ps

interface mem_port_if
    import arb_pkg::*, mem_pkg::*;
();

    // One-cycle strobe per issued command
    logic       valid;

    // Command word as granted
    mem_cmd_t   cmd;

    // Client that owns the command, used to steer the response
    client_id_t client;

    // Arbiter side drives the command
    modport arb (
        output valid,
        output cmd,
        output client
    );

    // Memory side takes every valid, no ready
    modport mem (
        input valid,
        input cmd,
        input client
    );

endinterface : mem_port_if

`default_nettype wire

/* common/mem_pkg.sv */
// Memory command types

`default_nettype none

`include "arb_settings.svh"

package mem_pkg;

    // Opcode, shared bit position in both command views
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Data word held in the array
    typedef logic [`ARB_DATA_W-1:0] mem_word_t;

    // Write view of a command word
    typedef struct packed {
        mem_op_e                op;
        logic [`ARB_ADDR_W-1:0] addr;
        mem_word_t              data;
    } mem_wr_cmd_t;

    // Read view, data field reused for the clear flag
    typedef struct packed {
        mem_op_e                op;
        logic [`ARB_ADDR_W-1:0] addr;
        logic                   clear;
        logic [`ARB_DATA_W-2:0] reserved;
    } mem_rd_cmd_t;

    // One command word, decoded by its opcode
    typedef union packed {
        mem_wr_cmd_t wr;
        mem_rd_cmd_t rd;
    } mem_cmd_t;

endpackage : mem_pkg

`default_nettype wire

/* common/arb_pkg.sv */
// Arbitration types

`default_nettype none

`include "arb_settings.svh"

package arb_pkg;

    // Client index, wide enough for every client
    typedef logic [$clog2(`ARB_NUM_CLIENTS)-1:0] client_id_t;

    // One bit per client
    // Used for requests, grants and response strobes
    typedef logic [`ARB_NUM_CLIENTS-1:0] client_mask_t;

endpackage : arb_pkg

`default_nettype wire

/* common/arb_settings.svh */
// Shared scratch memory settings

`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// Clients sharing the memory
`define ARB_NUM_CLIENTS 4

// Memory address width, 16 words
`define ARB_ADDR_W 4

// Memory data width
`define ARB_DATA_W 8

`endif
